// ==== list.f ====
+incdir+tests
hw/core_pkg.sv
hw/controller.sv
hw/stage_tracker.sv
hw/fpu_arbiter.sv
hw/fpu_sequencer.sv
hw/trap_regs.sv
hw/hazard_top.sv
tests/hazard_checker.sv
tests/tb_hazard.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the hazard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_hazard \
    -f list.f -Mdir obj_dir -o tb_hazard
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_hazard > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" sim.log; then
    exit 0
fi
exit 1

// ==== tests/tb_rows.svh ====
// Row and expected-output types of the hazard testbench
// Included at file scope by the testbench top and its checker
`ifndef TB_ROWS_SVH
`define TB_ROWS_SVH

// Every output of the hazard subsystem for one cycle
typedef struct packed {
    core_pkg::forward_t   fwd_rs1;
    core_pkg::forward_t   fwd_rs2;
    core_pkg::forward_t   fwd_rs3;
    logic                 stall_if;
    logic                 stall_id;
    logic                 flush_id;
    logic                 flush_ex;
    logic                 flush_mem;
    logic                 flush_wb;
    logic                 ext_gnt;
    core_pkg::pc_t        mepc;
    core_pkg::exc_cause_t mcause;
} exp_t;

// One stimulus row
// hold is the expected number of stalled cycles, 0 for a plain one-cycle row
typedef struct packed {
    logic [2:0]          group;
    core_pkg::id_instr_t instr;
    logic                branch;
    logic                misal;
    logic                ext_req;
    logic [4:0]          hold;
    exp_t                exp;
} row_t;

`endif

// ==== tests/tb_hazard.sv ====
// Testbench of the hazard and trap control subsystem
// Plays decoder and EX, applies the stimulus table one row per cycle
// Stall rows are held until stall_id_o falls and their stalled cycles are counted
`include "tb_rows.svh"

module tb_hazard;
    import core_pkg::*;

    localparam int HOLD_LIMIT = 20;

    logic       clk = 1'b0;
    logic       arst_n = 1'b0;
    id_instr_t  id_instr = '0;
    logic       branch = 1'b0;
    logic       misal = 1'b0;
    logic       ext_req = 1'b0;
    logic       check_en = 1'b0;
    exp_t       exp_row = '0;
    exp_t       act_out;

    forward_t   fwd_rs1;
    forward_t   fwd_rs2;
    forward_t   fwd_rs3;
    logic       stall_if;
    logic       stall_id;
    logic       flush_id;
    logic       flush_ex;
    logic       flush_mem;
    logic       flush_wb;
    logic       ext_gnt;
    pc_t        mepc;
    exc_cause_t mcause;

    row_t       rows[$];

    always #10 clk = ~clk;

    hazard_top #(
        .FPU_LATENCY (3)
    ) DUT (
        .clk_i                (clk),
        .arst_n_i             (arst_n),
        .id_instr_i           (id_instr),
        .branch_decision_ex_i (branch),
        .misaligned_ex_i      (misal),
        .ext_fpu_req_i        (ext_req),
        .fwd_rs1_o            (fwd_rs1),
        .fwd_rs2_o            (fwd_rs2),
        .fwd_rs3_o            (fwd_rs3),
        .stall_if_o           (stall_if),
        .stall_id_o           (stall_id),
        .flush_id_o           (flush_id),
        .flush_ex_o           (flush_ex),
        .flush_mem_o          (flush_mem),
        .flush_wb_o           (flush_wb),
        .ext_fpu_gnt_o        (ext_gnt),
        .mepc_o               (mepc),
        .mcause_o             (mcause)
    );

    always_comb begin
        act_out.fwd_rs1   = fwd_rs1;
        act_out.fwd_rs2   = fwd_rs2;
        act_out.fwd_rs3   = fwd_rs3;
        act_out.stall_if  = stall_if;
        act_out.stall_id  = stall_id;
        act_out.flush_id  = flush_id;
        act_out.flush_ex  = flush_ex;
        act_out.flush_mem = flush_mem;
        act_out.flush_wb  = flush_wb;
        act_out.ext_gnt   = ext_gnt;
        act_out.mepc      = mepc;
        act_out.mcause    = mcause;
    end

    hazard_checker u_check (
        .clk_i      (clk),
        .check_en_i (check_en),
        .exp_i      (exp_row),
        .act_i      (act_out)
    );

    ////////////////////////////////////////////////////////////
    // Table helpers
    ////////////////////////////////////////////////////////////

    // Sources default to x0, so they never match
    function automatic id_instr_t make_instr(reg_addr_t rd, reg_bank_mux_t bank,
                                             logic alu, logic ld, pc_t pc);
        id_instr_t r;
        r = '0;
        r.dst.rd      = rd;
        r.dst.bank    = bank;
        r.dst.alu_wen = alu;
        r.dst.mem_wen = ld;
        r.dst.pc      = pc;
        return r;
    endfunction

    // No forwarding, stall or flush
    function automatic exp_t quiet(pc_t pc, exc_cause_t cause);
        exp_t e;
        e = '0;
        e.mepc   = pc;
        e.mcause = cause;
        return e;
    endfunction

    // Stalled ID, with MEM flushed when EX is held by the FPU
    function automatic exp_t stall_out(logic fmem, logic egnt);
        exp_t e;
        e = quiet(32'h0, 5'd0);
        e.stall_if  = 1'b1;
        e.stall_id  = 1'b1;
        e.flush_id  = 1'b1;
        e.flush_ex  = 1'b1;
        e.flush_mem = fmem;
        e.ext_gnt   = egnt;
        return e;
    endfunction

    // Flags are branch, misaligned, ext request
    task automatic add_row(input logic [2:0] group, input id_instr_t instr,
                           input logic [2:0] flags, input logic [4:0] hold,
                           input exp_t e);
        row_t r;
        r.group   = group;
        r.instr   = instr;
        r.branch  = flags[2];
        r.misal   = flags[1];
        r.ext_req = flags[0];
        r.hold    = hold;
        r.exp     = e;
        rows.push_back(r);
    endtask

    function automatic string group_name(logic [2:0] group);
        case (group)
            3'd1: return "forwarding";
            3'd2: return "load-use";
            3'd3: return "fpu sharing";
            3'd4: return "control flow";
            default: return "traps";
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////

    task automatic build_table();
        id_instr_t ins;
        exp_t      e;
        // x5 written twice, then read as it ages through EX, MEM, WB
        add_row(3'd1, make_instr(5'd5, X_REG, 1'b1, 1'b0, 32'h100), 3'b000, 5'd0,
                quiet(32'h0, 5'd0));
        add_row(3'd1, make_instr(5'd5, X_REG, 1'b1, 1'b0, 32'h104), 3'b000, 5'd0,
                quiet(32'h0, 5'd0));
        ins = make_instr(5'd6, X_REG, 1'b1, 1'b0, 32'h108);
        ins.rs1 = 5'd5;
        e = quiet(32'h0, 5'd0);
        e.fwd_rs1 = FWD_EX_ALU_RES_TO_ID;
        add_row(3'd1, ins, 3'b000, 5'd0, e);
        // Write to x0 is never a forwarding source
        ins = make_instr(5'd0, X_REG, 1'b1, 1'b0, 32'h10c);
        ins.rs1 = 5'd5;
        e.fwd_rs1 = FWD_MEM_ALU_RES_TO_ID;
        add_row(3'd1, ins, 3'b000, 5'd0, e);
        ins = make_instr(5'd0, X_REG, 1'b0, 1'b0, 32'h110);
        ins.rs1 = 5'd5;
        ins.rs2 = 5'd6;
        e.fwd_rs1 = FWD_WB_ALU_RES_TO_ID;
        e.fwd_rs2 = FWD_MEM_ALU_RES_TO_ID;
        add_row(3'd1, ins, 3'b000, 5'd0, e);
        // f6 against x6 in WB, and x0 against the x0 write
        ins = make_instr(5'd0, F_REG, 1'b1, 1'b0, 32'h114);
        ins.rs2      = 5'd6;
        ins.rs2_bank = F_REG;
        add_row(3'd1, ins, 3'b000, 5'd0, quiet(32'h0, 5'd0));
        // f0 is a real destination
        ins = make_instr(5'd0, X_REG, 1'b0, 1'b0, 32'h118);
        ins.rs3_bank = F_REG;
        e = quiet(32'h0, 5'd0);
        e.fwd_rs3 = FWD_EX_ALU_RES_TO_ID;
        add_row(3'd1, ins, 3'b000, 5'd0, e);

        // Load to x7, then a reader of x7
        add_row(3'd2, make_instr(5'd7, X_REG, 1'b0, 1'b1, 32'h200), 3'b000, 5'd0,
                quiet(32'h0, 5'd0));
        ins = make_instr(5'd8, X_REG, 1'b1, 1'b0, 32'h204);
        ins.rs1 = 5'd7;
        add_row(3'd2, ins, 3'b000, 5'd1, stall_out(1'b0, 1'b0));
        e = quiet(32'h0, 5'd0);
        e.fwd_rs1 = FWD_MEM_RDATA_TO_ID;
        add_row(3'd2, ins, 3'b000, 5'd0, e);

        // Core wins the first conflict, then its run holds EX
        ins = make_instr(5'd1, F_REG, 1'b1, 1'b0, 32'h300);
        ins.fpu_req = 1'b1;
        add_row(3'd3, ins, 3'b001, 5'd0, quiet(32'h0, 5'd0));
        ins = make_instr(5'd2, F_REG, 1'b1, 1'b0, 32'h304);
        ins.fpu_req = 1'b1;
        add_row(3'd3, ins, 3'b000, 5'd3, stall_out(1'b1, 1'b0));
        add_row(3'd3, ins, 3'b000, 5'd0, quiet(32'h0, 5'd0));
        ins = make_instr(5'd9, X_REG, 1'b1, 1'b0, 32'h308);
        add_row(3'd3, ins, 3'b000, 5'd3, stall_out(1'b1, 1'b0));
        add_row(3'd3, ins, 3'b000, 5'd0, quiet(32'h0, 5'd0));
        // External port wins the next conflict, core waits for idle
        ins = make_instr(5'd3, F_REG, 1'b1, 1'b0, 32'h30c);
        ins.fpu_req = 1'b1;
        add_row(3'd3, ins, 3'b001, 5'd0, stall_out(1'b0, 1'b1));
        add_row(3'd3, ins, 3'b000, 5'd3, stall_out(1'b0, 1'b0));
        add_row(3'd3, ins, 3'b000, 5'd0, quiet(32'h0, 5'd0));
        ins = make_instr(5'd0, X_REG, 1'b0, 1'b0, 32'h310);
        add_row(3'd3, ins, 3'b000, 5'd3, stall_out(1'b1, 1'b0));
        add_row(3'd3, ins, 3'b000, 5'd0, quiet(32'h0, 5'd0));

        // JAL in ID, then a taken branch in EX
        ins = make_instr(5'd1, X_REG, 1'b1, 1'b0, 32'h400);
        ins.pc_source = PC_JAL;
        e = quiet(32'h0, 5'd0);
        e.flush_id = 1'b1;
        add_row(3'd4, ins, 3'b000, 5'd0, e);
        e.flush_ex = 1'b1;
        add_row(3'd4, make_instr(5'd0, X_REG, 1'b0, 1'b0, 32'h404), 3'b100, 5'd0, e);

        // Illegal in ID, saved one cycle later
        ins = make_instr(5'd0, X_REG, 1'b0, 1'b0, 32'h500);
        ins.illegal = 1'b1;
        add_row(3'd5, ins, 3'b000, 5'd0, e);
        add_row(3'd5, make_instr(5'd10, X_REG, 1'b1, 1'b0, 32'h504), 3'b000, 5'd0,
                quiet(32'h500, 5'd2));
        // Misaligned target in EX beats the ID trap
        ins = make_instr(5'd0, X_REG, 1'b0, 1'b0, 32'h508);
        ins.illegal = 1'b1;
        e = quiet(32'h500, 5'd2);
        e.flush_id  = 1'b1;
        e.flush_ex  = 1'b1;
        e.flush_mem = 1'b1;
        add_row(3'd5, ins, 3'b010, 5'd0, e);
        // Wrong-path trap under a taken branch
        ins = make_instr(5'd0, X_REG, 1'b0, 1'b0, 32'h50c);
        ins.illegal = 1'b1;
        e = quiet(32'h504, 5'd0);
        e.flush_id = 1'b1;
        e.flush_ex = 1'b1;
        add_row(3'd5, ins, 3'b100, 5'd0, e);
        add_row(3'd5, make_instr(5'd0, X_REG, 1'b0, 1'b0, 32'h510), 3'b000, 5'd0,
                quiet(32'h504, 5'd0));
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int idx;
        int held;
        bit timed_out;
        timed_out = 1'b0;
        build_table();
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        idx = 0;
        while (idx < rows.size() && !timed_out) begin
            @(posedge clk);
            #1;
            if (idx > 0 && rows[idx].group != rows[idx - 1].group) begin
                u_check.report_group(group_name(rows[idx - 1].group));
            end
            id_instr = rows[idx].instr;
            branch   = rows[idx].branch;
            misal    = rows[idx].misal;
            ext_req  = rows[idx].ext_req;
            exp_row  = rows[idx].exp;
            check_en = 1'b1;
            @(negedge clk);
            if (rows[idx].hold != 5'd0) begin
                held = 0;
                while (stall_id && !timed_out) begin
                    held++;
                    if (held > HOLD_LIMIT) begin
                        $display("row %0d: stall_id_o still high after %0d cycles",
                                 idx, HOLD_LIMIT);
                        timed_out = 1'b1;
                    end else begin
                        @(posedge clk);
                        #1;
                        @(negedge clk);
                    end
                end
                if (!timed_out) begin
                    u_check.check_field("stall_id_o cycles", 32'(rows[idx].hold),
                                        32'(held));
                    // Release row repeats the stalled instruction
                    idx++;
                    exp_row = rows[idx].exp;
                end
            end
            idx++;
        end
        @(posedge clk);
        check_en = 1'b0;
        u_check.report_group(group_name(rows[idx - 1].group));
        $display("total: %0d checks, %0d errors", u_check.checks, u_check.errors);
        if (u_check.errors == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/hazard_checker.sv ====
// Compares the hazard subsystem outputs with the expected row
// Samples 1 unit after the falling edge, when inputs and outputs are settled
`include "tb_rows.svh"

module hazard_checker (
    input logic clk_i,
    input logic check_en_i,
    input exp_t exp_i,
    input exp_t act_i
);

    int checks = 0;
    int errors = 0;
    int group_checks = 0;
    int group_errors = 0;

    task automatic check_field(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        checks++;
        group_checks++;
        if (exp_val !== act_val) begin
            errors++;
            group_errors++;
            $display("FAILED time %0t: %s expected 0x%0h actual 0x%0h",
                     $time, name, exp_val, act_val);
        end
    endtask

    // One summary line per test group
    task automatic report_group(input string name);
        $display("%s: %0d checks, %0d errors", name, group_checks, group_errors);
        group_checks = 0;
        group_errors = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // Per-cycle compare
    ////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin
        #1;
        if (check_en_i) begin
            check_field("fwd_rs1_o", 32'(exp_i.fwd_rs1), 32'(act_i.fwd_rs1));
            check_field("fwd_rs2_o", 32'(exp_i.fwd_rs2), 32'(act_i.fwd_rs2));
            check_field("fwd_rs3_o", 32'(exp_i.fwd_rs3), 32'(act_i.fwd_rs3));
            check_field("stall_if_o", 32'(exp_i.stall_if), 32'(act_i.stall_if));
            check_field("stall_id_o", 32'(exp_i.stall_id), 32'(act_i.stall_id));
            check_field("flush_id_o", 32'(exp_i.flush_id), 32'(act_i.flush_id));
            check_field("flush_ex_o", 32'(exp_i.flush_ex), 32'(act_i.flush_ex));
            check_field("flush_mem_o", 32'(exp_i.flush_mem), 32'(act_i.flush_mem));
            check_field("flush_wb_o", 32'(exp_i.flush_wb), 32'(act_i.flush_wb));
            check_field("ext_fpu_gnt_o", 32'(exp_i.ext_gnt), 32'(act_i.ext_gnt));
            check_field("mepc_o", exp_i.mepc, act_i.mepc);
            check_field("mcause_o", 32'(exp_i.mcause), 32'(act_i.mcause));
        end
    end

endmodule

// ==== hw/hazard_top.sv ====
// Top of the hazard and trap control subsystem
// Joins the controller, stage tags, FPU arbiter and sequencer and trap registers
module hazard_top #(
    parameter int unsigned FPU_LATENCY = 3
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  core_pkg::id_instr_t  id_instr_i,
    input  logic                 branch_decision_ex_i,
    input  logic                 misaligned_ex_i,
    input  logic                 ext_fpu_req_i,
    output core_pkg::forward_t   fwd_rs1_o,
    output core_pkg::forward_t   fwd_rs2_o,
    output core_pkg::forward_t   fwd_rs3_o,
    output logic                 stall_if_o,
    output logic                 stall_id_o,
    output logic                 flush_id_o,
    output logic                 flush_ex_o,
    output logic                 flush_mem_o,
    output logic                 flush_wb_o,
    output logic                 ext_fpu_gnt_o,
    output core_pkg::pc_t        mepc_o,
    output core_pkg::exc_cause_t mcause_o
);
    import core_pkg::*;

    // Tags of the older stages
    stage_tag_t ex_tag;
    stage_tag_t mem_tag;
    stage_tag_t wb_tag;

    logic       stall_ex;
    logic       stall_load_use;
    logic       fpu_gnt_id;
    logic       fpu_busy_ex;
    logic       fpu_idle;
    logic       save_pc_id;
    logic       save_pc_ex;
    exc_cause_t exception_cause;

    controller u_controller (
        .clk_i                (clk_i),
        .arst_n_i             (arst_n_i),
        .id_instr_i           (id_instr_i),
        .ex_tag_i             (ex_tag),
        .mem_tag_i            (mem_tag),
        .wb_tag_i             (wb_tag),
        .branch_decision_ex_i (branch_decision_ex_i),
        .misaligned_ex_i      (misaligned_ex_i),
        .fpu_gnt_id_i         (fpu_gnt_id),
        .fpu_busy_ex_i        (fpu_busy_ex),
        .fwd_rs1_o            (fwd_rs1_o),
        .fwd_rs2_o            (fwd_rs2_o),
        .fwd_rs3_o            (fwd_rs3_o),
        .stall_if_o           (stall_if_o),
        .stall_id_o           (stall_id_o),
        .stall_ex_o           (stall_ex),
        .stall_load_use_o     (stall_load_use),
        .flush_id_o           (flush_id_o),
        .flush_ex_o           (flush_ex_o),
        .flush_mem_o          (flush_mem_o),
        .flush_wb_o           (flush_wb_o),
        .save_pc_id_o         (save_pc_id),
        .save_pc_ex_o         (save_pc_ex),
        .exception_cause_o    (exception_cause)
    );

    stage_tracker u_stage_tracker (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .id_dst_i    (id_instr_i.dst),
        .stall_ex_i  (stall_ex),
        .flush_ex_i  (flush_ex_o),
        .flush_mem_i (flush_mem_o),
        .ex_tag_o    (ex_tag),
        .mem_tag_o   (mem_tag),
        .wb_tag_o    (wb_tag)
    );

    // Load-use stall keeps the core from taking a grant it cannot use
    fpu_arbiter u_fpu_arbiter (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .core_req_i  (id_instr_i.fpu_req),
        .ext_req_i   (ext_fpu_req_i),
        .core_hold_i (stall_load_use),
        .fpu_idle_i  (fpu_idle),
        .core_gnt_o  (fpu_gnt_id),
        .ext_gnt_o   (ext_fpu_gnt_o)
    );

    fpu_sequencer #(
        .FPU_LATENCY (FPU_LATENCY)
    ) u_fpu_sequencer (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .core_gnt_i  (fpu_gnt_id),
        .ext_gnt_i   (ext_fpu_gnt_o),
        .idle_o      (fpu_idle),
        .core_busy_o (fpu_busy_ex)
    );

    trap_regs u_trap_regs (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .save_pc_id_i (save_pc_id),
        .save_pc_ex_i (save_pc_ex),
        .id_pc_i      (id_instr_i.dst.pc),
        .ex_pc_i      (ex_tag.pc),
        .cause_i      (exception_cause),
        .mepc_o       (mepc_o),
        .mcause_o     (mcause_o)
    );

endmodule

// ==== hw/trap_regs.sv ====
// mepc and mcause of the last saved trap
// Written on the edge after a save pulse, held until the next one
module trap_regs (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 save_pc_id_i,
    input  logic                 save_pc_ex_i,
    input  core_pkg::pc_t        id_pc_i,
    input  core_pkg::pc_t        ex_pc_i,
    input  core_pkg::exc_cause_t cause_i,
    output core_pkg::pc_t        mepc_o,
    output core_pkg::exc_cause_t mcause_o
);
    import core_pkg::*;

    pc_t        mepc_q;
    exc_cause_t mcause_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mepc_q   <= '0;
            mcause_q <= '0;
        end else if (save_pc_ex_i || save_pc_id_i) begin
            // EX PC when the older stage trapped
            mepc_q   <= save_pc_ex_i ? ex_pc_i : id_pc_i;
            mcause_q <= cause_i;
        end
    end

    assign mepc_o   = mepc_q;
    assign mcause_o = mcause_q;

endmodule

// ==== hw/fpu_sequencer.sv ====
// Timing stand-in for the FPU
// Stays busy FPU_LATENCY cycles after any grant and tracks who owns the run
module fpu_sequencer #(
    parameter int unsigned FPU_LATENCY = 3
) (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic core_gnt_i,
    input  logic ext_gnt_i,
    output logic idle_o,
    output logic core_busy_o
);

    typedef enum logic {
        FPU_IDLE,
        FPU_RUN
    } fpu_state_t;

    fpu_state_t state_q;
    // Cycles left in the run, minus one
    logic [3:0] cnt_q;
    // Run was started by the core
    logic       owner_core_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= FPU_IDLE;
            cnt_q        <= '0;
            owner_core_q <= 1'b0;
        end else begin
            case (state_q)
                FPU_IDLE: begin
                    if (core_gnt_i || ext_gnt_i) begin
                        state_q      <= FPU_RUN;
                        cnt_q        <= 4'(FPU_LATENCY - 1);
                        owner_core_q <= core_gnt_i;
                    end
                end
                FPU_RUN: begin
                    // Last busy cycle
                    if (cnt_q == '0) begin
                        state_q <= FPU_IDLE;
                    end else begin
                        cnt_q <= cnt_q - 4'd1;
                    end
                end
                default: state_q <= FPU_IDLE;
            endcase
        end
    end

    assign idle_o      = (state_q == FPU_IDLE);
    // External runs do not stall the core EX stage
    assign core_busy_o = (state_q == FPU_RUN) && owner_core_q;

    // Arbiter never grants into a running operation
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (core_gnt_i || ext_gnt_i) |-> (state_q == FPU_IDLE));

endmodule

// ==== hw/fpu_arbiter.sv ====
// Shares the single FPU between the core ID stage and the external port
// Requests and grants are plain levels; priority alternates on conflict
module fpu_arbiter (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic core_req_i,
    input  logic ext_req_i,
    input  logic core_hold_i,
    input  logic fpu_idle_i,
    output logic core_gnt_o,
    output logic ext_gnt_o
);

    // High when the external port wins the next conflict
    logic prio_ext_q;
    logic core_ok;

    // Core request is void while ID waits on a load
    assign core_ok = core_req_i && !core_hold_i;

    // Grants only into an idle FPU
    assign core_gnt_o = fpu_idle_i && core_ok && (!ext_req_i || !prio_ext_q);
    assign ext_gnt_o  = fpu_idle_i && ext_req_i && (!core_ok || prio_ext_q);

    // Winner drops to the back
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prio_ext_q <= 1'b0;
        end else if (core_gnt_o) begin
            prio_ext_q <= 1'b1;
        end else if (ext_gnt_o) begin
            prio_ext_q <= 1'b0;
        end
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(core_gnt_o && ext_gnt_o));

endmodule

// ==== hw/stage_tracker.sv ====
// Destination tags of the instructions in EX, MEM and WB
// Advances every edge; EX holds on stall, flushed stages take a bubble
module stage_tracker (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  core_pkg::stage_tag_t id_dst_i,
    input  logic                 stall_ex_i,
    input  logic                 flush_ex_i,
    input  logic                 flush_mem_i,
    output core_pkg::stage_tag_t ex_tag_o,
    output core_pkg::stage_tag_t mem_tag_o,
    output core_pkg::stage_tag_t wb_tag_o
);
    import core_pkg::*;

    // No write enables, x0 destination
    localparam stage_tag_t BUBBLE = '0;

    stage_tag_t ex_tag_q;
    stage_tag_t mem_tag_q;
    stage_tag_t wb_tag_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_tag_q  <= BUBBLE;
            mem_tag_q <= BUBBLE;
            wb_tag_q  <= BUBBLE;
        end else begin
            // Stall beats flush in EX
            if (!stall_ex_i) begin
                ex_tag_q <= flush_ex_i ? BUBBLE : id_dst_i;
            end
            mem_tag_q <= flush_mem_i ? BUBBLE : ex_tag_q;
            // WB always follows MEM
            wb_tag_q  <= mem_tag_q;
        end
    end

    assign ex_tag_o  = ex_tag_q;
    assign mem_tag_o = mem_tag_q;
    assign wb_tag_o  = wb_tag_q;

    // A destination is written by the ALU or by a load, never both
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(ex_tag_q.alu_wen && ex_tag_q.mem_wen));

endmodule

// ==== hw/controller.sv ====
// Hazard controller of the in-order pipeline
// Purely combinational: forwarding selects, stalls, flushes and trap cause
// Clock and reset only feed the checks at the bottom
module controller (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    // Decoded ID instruction and the tags further down
    input  core_pkg::id_instr_t    id_instr_i,
    input  core_pkg::stage_tag_t   ex_tag_i,
    input  core_pkg::stage_tag_t   mem_tag_i,
    input  core_pkg::stage_tag_t   wb_tag_i,
    // EX outcome and FPU status
    input  logic                   branch_decision_ex_i,
    input  logic                   misaligned_ex_i,
    input  logic                   fpu_gnt_id_i,
    input  logic                   fpu_busy_ex_i,
    // Forwarding
    output core_pkg::forward_t     fwd_rs1_o,
    output core_pkg::forward_t     fwd_rs2_o,
    output core_pkg::forward_t     fwd_rs3_o,
    // Stalls
    output logic                   stall_if_o,
    output logic                   stall_id_o,
    output logic                   stall_ex_o,
    output logic                   stall_load_use_o,
    // Flushes
    output logic                   flush_id_o,
    output logic                   flush_ex_o,
    output logic                   flush_mem_o,
    output logic                   flush_wb_o,
    // Trap save
    output logic                   save_pc_id_o,
    output logic                   save_pc_ex_o,
    output core_pkg::exc_cause_t   exception_cause_o
);
    import core_pkg::*;

    logic ex_hits_src;
    logic fpu_gnt_stall;
    logic trap_id;
    logic trap_ex;
    logic id_is_jump;

    // f is always a real destination, x only when nonzero
    function automatic logic dst_valid(stage_tag_t tag);
        return (tag.bank == F_REG) || (tag.rd != '0);
    endfunction

    function automatic logic dst_match(stage_tag_t tag, reg_addr_t rs, reg_bank_mux_t bank);
        return dst_valid(tag) && (tag.rd == rs) && (tag.bank == bank);
    endfunction

    // Youngest stage first, ALU result before read data
    function automatic forward_t resolve_fwd(reg_addr_t rs, reg_bank_mux_t bank,
                                             stage_tag_t ex, stage_tag_t mem,
                                             stage_tag_t wb);
        forward_t fwd;
        fwd = NO_FORWARD;
        if (dst_match(ex, rs, bank) && ex.alu_wen) begin
            fwd = FWD_EX_ALU_RES_TO_ID;
        end else if (dst_match(mem, rs, bank) && mem.alu_wen) begin
            fwd = FWD_MEM_ALU_RES_TO_ID;
        end else if (dst_match(mem, rs, bank) && mem.mem_wen) begin
            fwd = FWD_MEM_RDATA_TO_ID;
        end else if (dst_match(wb, rs, bank) && wb.alu_wen) begin
            fwd = FWD_WB_ALU_RES_TO_ID;
        end else if (dst_match(wb, rs, bank) && wb.mem_wen) begin
            fwd = FWD_WB_RDATA_TO_ID;
        end
        return fwd;
    endfunction

    ////////////////////////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////////////////////////

    assign fwd_rs1_o = resolve_fwd(id_instr_i.rs1, id_instr_i.rs1_bank,
                                   ex_tag_i, mem_tag_i, wb_tag_i);
    assign fwd_rs2_o = resolve_fwd(id_instr_i.rs2, id_instr_i.rs2_bank,
                                   ex_tag_i, mem_tag_i, wb_tag_i);
    assign fwd_rs3_o = resolve_fwd(id_instr_i.rs3, id_instr_i.rs3_bank,
                                   ex_tag_i, mem_tag_i, wb_tag_i);

    ////////////////////////////////////////////////////////////
    // Stalls
    ////////////////////////////////////////////////////////////

    // Any ID source written by the instruction now in EX
    assign ex_hits_src = dst_match(ex_tag_i, id_instr_i.rs1, id_instr_i.rs1_bank)
                      || dst_match(ex_tag_i, id_instr_i.rs2, id_instr_i.rs2_bank)
                      || dst_match(ex_tag_i, id_instr_i.rs3, id_instr_i.rs3_bank);

    // Load data not ready before MEM
    assign stall_load_use_o = ex_tag_i.mem_wen && ex_hits_src;
    // FPU wanted but not granted this cycle
    assign fpu_gnt_stall    = id_instr_i.fpu_req && !fpu_gnt_id_i;

    // FPU busy holds EX, and the stall ripples back to ID and IF
    assign stall_ex_o = fpu_busy_ex_i;
    assign stall_id_o = stall_ex_o || fpu_gnt_stall || stall_load_use_o;
    assign stall_if_o = stall_id_o;

    ////////////////////////////////////////////////////////////
    // Flushes
    ////////////////////////////////////////////////////////////

    assign trap_id    = id_instr_i.illegal || id_instr_i.misaligned;
    assign trap_ex    = misaligned_ex_i;
    assign id_is_jump = (id_instr_i.pc_source == PC_JAL) || (id_instr_i.pc_source == PC_JALR);

    // Each older flush implies all younger ones
    // MEM never stalls, so WB is never flushed
    assign flush_wb_o  = 1'b0;
    assign flush_mem_o = flush_wb_o || trap_ex || stall_ex_o;
    assign flush_ex_o  = flush_mem_o || branch_decision_ex_i || stall_id_o || trap_id;
    assign flush_id_o  = flush_ex_o || id_is_jump;

    ////////////////////////////////////////////////////////////
    // Trap PC and cause
    ////////////////////////////////////////////////////////////

    always_comb begin
        save_pc_ex_o      = 1'b0;
        save_pc_id_o      = 1'b0;
        exception_cause_o = '0;
        // Older EX trap wins
        if (trap_ex) begin
            save_pc_ex_o      = 1'b1;
            exception_cause_o = EXC_CAUSE_INSTR_ADDR_MISAL;
        // ID trap is wrong-path under a taken branch
        end else if (trap_id && !branch_decision_ex_i && !id_instr_i.mret) begin
            save_pc_id_o = 1'b1;
            if (id_instr_i.illegal) begin
                exception_cause_o = EXC_CAUSE_ILLEGAL_INSN;
            end else begin
                exception_cause_o = EXC_CAUSE_INSTR_ADDR_MISAL;
            end
        end
    end

    // Only one PC goes to mepc per cycle
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(save_pc_id_o && save_pc_ex_o));

    // Bubble put into EX is never held by the FPU on the next cycle
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (flush_ex_o && !stall_ex_o) |=> !stall_ex_o);

endmodule

// ==== hw/core_pkg.sv ====
// Shared types of the hazard and trap control for the in-order core
// Every RTL block of the subsystem takes its widths, enums and tags from here
package core_pkg;

    // Widths with a meaning of their own
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  exc_cause_t;

    // mcause codes raised by this pipeline
    localparam exc_cause_t EXC_CAUSE_INSTR_ADDR_MISAL = 5'd0;
    localparam exc_cause_t EXC_CAUSE_ILLEGAL_INSN     = 5'd2;

    // Register bank of a source or destination
    typedef enum logic {
        X_REG = 1'b0,
        F_REG = 1'b1
    } reg_bank_mux_t;

    // Operand source select for the ID stage
    typedef enum logic [2:0] {
        NO_FORWARD,
        FWD_EX_ALU_RES_TO_ID,
        FWD_MEM_ALU_RES_TO_ID,
        FWD_MEM_RDATA_TO_ID,
        FWD_WB_ALU_RES_TO_ID,
        FWD_WB_RDATA_TO_ID
    } forward_t;

    // Next PC source as decoded in ID
    typedef enum logic [1:0] {
        PC_NEXT,
        PC_JAL,
        PC_JALR,
        PC_BRANCH
    } pc_source_t;

    // Destination of one instruction, carried down the pipe
    // All zero is a bubble
    typedef struct packed {
        reg_addr_t     rd;
        reg_bank_mux_t bank;
        logic          alu_wen;
        logic          mem_wen;
        pc_t           pc;
    } stage_tag_t;

    // Decoded instruction sitting in ID
    typedef struct packed {
        reg_addr_t     rs1;
        reg_bank_mux_t rs1_bank;
        reg_addr_t     rs2;
        reg_bank_mux_t rs2_bank;
        reg_addr_t     rs3;
        reg_bank_mux_t rs3_bank;
        stage_tag_t    dst;
        pc_source_t    pc_source;
        logic          illegal;
        logic          misaligned;
        logic          mret;
        logic          fpu_req;
    } id_instr_t;

endpackage
